/* bench/tb_decode_stage.sv */
`default_nettype none
`timescale 1ns/1ns

`include "decode_macros.svh"

module tb_decode_stage;
    import decode_pkg::*;

    localparam int          CLK_PERIOD  = 20;
    localparam int          NUM_TESTS   = 4000;
    localparam int          WATCHDOG_NS = (NUM_TESTS + 100) * CLK_PERIOD;
    localparam logic [31:0] SEED        = 32'hd0226f21;

    // alu operation bits from overflow trap down to lui
    localparam alu_op_t ALU_NO   = 14'h0000;
    localparam alu_op_t ALU_OVF  = 14'h2000;
    localparam alu_op_t ALU_HILO = 14'h1000;
    localparam alu_op_t ALU_ADD  = 14'h0800;
    localparam alu_op_t ALU_SUB  = 14'h0400;
    localparam alu_op_t ALU_SLT  = 14'h0200;
    localparam alu_op_t ALU_SLTU = 14'h0100;
    localparam alu_op_t ALU_AND  = 14'h0080;
    localparam alu_op_t ALU_NOR  = 14'h0040;
    localparam alu_op_t ALU_OR   = 14'h0020;
    localparam alu_op_t ALU_XOR  = 14'h0010;
    localparam alu_op_t ALU_SLL  = 14'h0008;
    localparam alu_op_t ALU_SRL  = 14'h0004;
    localparam alu_op_t ALU_SRA  = 14'h0002;
    localparam alu_op_t ALU_LUI  = 14'h0001;

    localparam src1_sel_t S1_NO    = 3'b000;
    localparam src1_sel_t S1_RS    = 3'b001;
    localparam src1_sel_t S1_PC    = 3'b010;
    localparam src1_sel_t S1_SA    = 3'b100;
    localparam src2_sel_t S2_NO    = 4'b0000;
    localparam src2_sel_t S2_RT    = 4'b0001;
    localparam src2_sel_t S2_SIMM  = 4'b0010;
    localparam src2_sel_t S2_EIGHT = 4'b0100;
    localparam src2_sel_t S2_ZIMM  = 4'b1000;

    localparam int DST_NO   = 0;
    localparam int DST_RD   = 1;
    localparam int DST_RT   = 2;
    localparam int DST_LINK = 3;

    localparam int F_BR    = 0;
    localparam int F_HILO  = 1;
    localparam int F_CP0   = 2;
    localparam int F_EXC   = 3;
    localparam int F_LOAD  = 4;
    localparam int F_STORE = 5;

    // encodings used to build kept instructions
    localparam opcode_t SPECIAL_FN [28] = '{
        `DEC_FN_SLL, `DEC_FN_SRL, `DEC_FN_SRA, `DEC_FN_SLLV, `DEC_FN_SRLV, `DEC_FN_SRAV,
        `DEC_FN_JR, `DEC_FN_JALR, `DEC_FN_SYSCALL, `DEC_FN_BREAK, `DEC_FN_MFHI,
        `DEC_FN_MTHI, `DEC_FN_MFLO, `DEC_FN_MTLO, `DEC_FN_MULT, `DEC_FN_MULTU,
        `DEC_FN_DIV, `DEC_FN_DIVU, `DEC_FN_ADD, `DEC_FN_ADDU, `DEC_FN_SUB, `DEC_FN_SUBU,
        `DEC_FN_AND, `DEC_FN_OR, `DEC_FN_XOR, `DEC_FN_NOR, `DEC_FN_SLT, `DEC_FN_SLTU
    };
    localparam opcode_t MAJOR_OP [22] = '{
        6'b000010, 6'b000011, 6'b000100, 6'b000101, 6'b000110, 6'b000111,
        6'b001000, 6'b001001, 6'b001010, 6'b001011, 6'b001100, 6'b001101,
        6'b001110, 6'b001111, 6'b100000, 6'b100001, 6'b100011, 6'b100100,
        6'b100101, 6'b101000, 6'b101001, 6'b101011
    };
    localparam reg_addr_t REGIMM_RT [4] = '{5'd0, 5'd1, 5'd16, 5'd17};
    // beql, lwl, swr, cache
    localparam opcode_t DROPPED_OP [4] = '{6'b010100, 6'b100010, 6'b101110, 6'b101111};

    typedef struct packed {
        logic      valid;
        br_op_t    br_op;
        hilo_op_t  hilo_op;
        mem_op_t   mem_op;
        cp0_op_t   cp0_op;
        src1_sel_t src1;
        src2_sel_t src2;
        alu_op_t   alu_op;
        logic      ram_en;
        ram_wen_t  ram_wen;
        logic      rf_we;
        reg_addr_t waddr;
        logic      rf_res;
        exc_t      exc;
    } exp_t;

    localparam exp_t NO_OUTPUT = '0;

    logic      clk;
    logic      i_rst_n;
    logic      i_valid;
    inst_t     i_inst;
    logic      o_valid;
    br_op_t    o_br_op;
    hilo_op_t  o_hilo_op;
    mem_op_t   o_mem_op;
    cp0_op_t   o_cp0_op;
    src1_sel_t o_sel_alu_src1;
    src2_sel_t o_sel_alu_src2;
    alu_op_t   o_alu_op;
    logic      o_data_ram_en;
    ram_wen_t  o_data_ram_wen;
    logic      o_rf_we;
    reg_addr_t o_rf_waddr;
    logic      o_sel_rf_res;
    exc_t      o_excepttype;

    exp_t exp_q [$];
    int   n_checks = 0;
    int   n_errors = 0;

    decode_stage DUT (
        .i_clk          (clk),
        .i_rst_n        (i_rst_n),
        .i_valid        (i_valid),
        .i_inst         (i_inst),
        .o_valid        (o_valid),
        .o_br_op        (o_br_op),
        .o_hilo_op      (o_hilo_op),
        .o_mem_op       (o_mem_op),
        .o_cp0_op       (o_cp0_op),
        .o_sel_alu_src1 (o_sel_alu_src1),
        .o_sel_alu_src2 (o_sel_alu_src2),
        .o_alu_op       (o_alu_op),
        .o_data_ram_en  (o_data_ram_en),
        .o_data_ram_wen (o_data_ram_wen),
        .o_rf_we        (o_rf_we),
        .o_rf_waddr     (o_rf_waddr),
        .o_sel_rf_res   (o_sel_rf_res),
        .o_excepttype   (o_excepttype)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic exp_t ctl_row(input alu_op_t alu, input src1_sel_t s1,
                                     input src2_sel_t s2, input int dst, input inst_t w);
        exp_t r;
        r = '0;
        r.valid  = 1'b1;
        r.alu_op = alu;
        r.src1   = s1;
        r.src2   = s2;
        r.rf_we  = (dst != DST_NO);
        case (dst)
            DST_RD:   r.waddr = w[15:11];
            DST_RT:   r.waddr = w[20:16];
            DST_LINK: r.waddr = `DEC_LINK_REG;
            default:  r.waddr = '0;
        endcase
        return r;
    endfunction

    function automatic exp_t one_hot(input int fld, input int i);
        exp_t f;
        f = '0;
        case (fld)
            F_BR:    f.br_op   = br_op_t'(1) << i;
            F_HILO:  f.hilo_op = hilo_op_t'(1) << i;
            F_CP0:   f.cp0_op  = cp0_op_t'(1) << i;
            F_EXC:   f.exc     = exc_t'(1) << i;
            F_LOAD: begin
                f.mem_op = mem_op_t'(1) << i;
                f.ram_en = 1'b1;
                f.rf_res = 1'b1;
            end
            F_STORE: begin
                f.ram_wen = ram_wen_t'(1) << i;
                f.ram_en  = 1'b1;
            end
            default: ;
        endcase
        return f;
    endfunction

    // reference decode straight from the opcode and function tables
    function automatic exp_t decode_model(input inst_t w);
        exp_t e;
        exp_t base;
        exp_t link;
        exp_t rs_only;
        exp_t rs_rt;
        exp_t hilo_rd;
        exp_t ld;
        exp_t st;
        base    = ctl_row(ALU_NO, S1_NO, S2_NO, DST_NO, w);
        link    = ctl_row(ALU_ADD, S1_PC, S2_EIGHT, DST_LINK, w);
        rs_only = ctl_row(ALU_NO, S1_RS, S2_NO, DST_NO, w);
        rs_rt   = ctl_row(ALU_NO, S1_RS, S2_RT, DST_NO, w);
        hilo_rd = ctl_row(ALU_HILO, S1_NO, S2_NO, DST_RD, w);
        ld      = ctl_row(ALU_ADD, S1_RS, S2_SIMM, DST_RT, w);
        st      = ctl_row(ALU_ADD, S1_RS, S2_SIMM, DST_NO, w);
        e       = base | one_hot(F_EXC, `DEC_EXC_INVALID);
        case (w[31:26])
            `DEC_OPC_SPECIAL: begin
                case (w[5:0])
                    `DEC_FN_SLL:     e = ctl_row(ALU_SLL, S1_SA, S2_RT, DST_RD, w);
                    `DEC_FN_SRL:     e = ctl_row(ALU_SRL, S1_SA, S2_RT, DST_RD, w);
                    `DEC_FN_SRA:     e = ctl_row(ALU_SRA, S1_SA, S2_RT, DST_RD, w);
                    `DEC_FN_SLLV:    e = ctl_row(ALU_SLL, S1_RS, S2_RT, DST_RD, w);
                    `DEC_FN_SRLV:    e = ctl_row(ALU_SRL, S1_RS, S2_RT, DST_RD, w);
                    `DEC_FN_SRAV:    e = ctl_row(ALU_SRA, S1_RS, S2_RT, DST_RD, w);
                    `DEC_FN_JR:      e = base | one_hot(F_BR, 1);
                    `DEC_FN_JALR:    e = link | one_hot(F_BR, 0);
                    `DEC_FN_SYSCALL: e = base | one_hot(F_EXC, `DEC_EXC_SYSCALL);
                    `DEC_FN_BREAK:   e = base | one_hot(F_EXC, `DEC_EXC_BREAK);
                    `DEC_FN_MFHI:    e = hilo_rd | one_hot(F_HILO, 8);
                    `DEC_FN_MFLO:    e = hilo_rd | one_hot(F_HILO, 7);
                    `DEC_FN_MTHI:    e = rs_only | one_hot(F_HILO, 6);
                    `DEC_FN_MTLO:    e = rs_only | one_hot(F_HILO, 5);
                    `DEC_FN_MULT:    e = rs_rt | one_hot(F_HILO, 4);
                    `DEC_FN_MULTU:   e = rs_rt | one_hot(F_HILO, 3);
                    `DEC_FN_DIV:     e = rs_rt | one_hot(F_HILO, 2);
                    `DEC_FN_DIVU:    e = rs_rt | one_hot(F_HILO, 1);
                    `DEC_FN_ADD:     e = ctl_row(ALU_OVF | ALU_ADD, S1_RS, S2_RT, DST_RD, w);
                    `DEC_FN_ADDU:    e = ctl_row(ALU_ADD, S1_RS, S2_RT, DST_RD, w);
                    `DEC_FN_SUB:     e = ctl_row(ALU_OVF | ALU_SUB, S1_RS, S2_RT, DST_RD, w);
                    `DEC_FN_SUBU:    e = ctl_row(ALU_SUB, S1_RS, S2_RT, DST_RD, w);
                    `DEC_FN_AND:     e = ctl_row(ALU_AND, S1_RS, S2_RT, DST_RD, w);
                    `DEC_FN_OR:      e = ctl_row(ALU_OR, S1_RS, S2_RT, DST_RD, w);
                    `DEC_FN_XOR:     e = ctl_row(ALU_XOR, S1_RS, S2_RT, DST_RD, w);
                    `DEC_FN_NOR:     e = ctl_row(ALU_NOR, S1_RS, S2_RT, DST_RD, w);
                    `DEC_FN_SLT:     e = ctl_row(ALU_SLT, S1_RS, S2_RT, DST_RD, w);
                    `DEC_FN_SLTU:    e = ctl_row(ALU_SLTU, S1_RS, S2_RT, DST_RD, w);
                    default: ;
                endcase
            end
            `DEC_OPC_REGIMM: begin
                case (w[20:16])
                    5'd0:    e = base | one_hot(F_BR, 6);
                    5'd1:    e = base | one_hot(F_BR, 9);
                    5'd16:   e = link | one_hot(F_BR, 4);
                    5'd17:   e = link | one_hot(F_BR, 5);
                    default: ;
                endcase
            end
            `DEC_OPC_COP0: begin
                case (w[25:21])
                    5'b00000: e = ctl_row(ALU_NO, S1_NO, S2_NO, DST_RT, w) | one_hot(F_CP0, 1);
                    5'b00100: e = base | one_hot(F_CP0, 0);
                    5'b10000: begin
                        if (w[5:0] == `DEC_FN_ERET)
                            e = base | one_hot(F_EXC, `DEC_EXC_ERET);
                    end
                    default: ;
                endcase
            end
            `DEC_OPC_SPECIAL2: begin
                if (w[5:0] == `DEC_FN_MUL)
                    e = ctl_row(ALU_NO, S1_RS, S2_RT, DST_RD, w) | one_hot(F_HILO, 0);
            end
            6'b000010: e = base | one_hot(F_BR, 3);
            6'b000011: e = link | one_hot(F_BR, 2);
            6'b000100: e = base | one_hot(F_BR, 11);
            6'b000101: e = base | one_hot(F_BR, 10);
            6'b000110: e = base | one_hot(F_BR, 7);
            6'b000111: e = base | one_hot(F_BR, 8);
            6'b001000: e = ctl_row(ALU_OVF | ALU_ADD, S1_RS, S2_SIMM, DST_RT, w);
            6'b001001: e = ctl_row(ALU_ADD, S1_RS, S2_SIMM, DST_RT, w);
            6'b001010: e = ctl_row(ALU_SLT, S1_RS, S2_SIMM, DST_RT, w);
            6'b001011: e = ctl_row(ALU_SLTU, S1_RS, S2_SIMM, DST_RT, w);
            6'b001100: e = ctl_row(ALU_AND, S1_RS, S2_ZIMM, DST_RT, w);
            6'b001101: e = ctl_row(ALU_OR, S1_RS, S2_ZIMM, DST_RT, w);
            6'b001110: e = ctl_row(ALU_XOR, S1_RS, S2_ZIMM, DST_RT, w);
            6'b001111: e = ctl_row(ALU_LUI, S1_NO, S2_SIMM, DST_RT, w);
            6'b100000: e = ld | one_hot(F_LOAD, 4);
            6'b100100: e = ld | one_hot(F_LOAD, 3);
            6'b100001: e = ld | one_hot(F_LOAD, 2);
            6'b100101: e = ld | one_hot(F_LOAD, 1);
            6'b100011: e = ld | one_hot(F_LOAD, 0);
            6'b101000: e = st | one_hot(F_STORE, 2);
            6'b101001: e = st | one_hot(F_STORE, 1);
            6'b101011: e = st | one_hot(F_STORE, 0);
            default: ;
        endcase
        return e;
    endfunction

    // a kept instruction with random register and immediate fields
    function automatic inst_t kept_inst(input int unsigned sel, input inst_t rnd);
        if (sel < 28)
            return {`DEC_OPC_SPECIAL, rnd[25:6], SPECIAL_FN[5'(sel)]};
        else if (sel < 50)
            return {MAJOR_OP[5'(sel - 28)], rnd[25:0]};
        else if (sel < 54)
            return {`DEC_OPC_REGIMM, rnd[25:21], REGIMM_RT[2'(sel - 50)], rnd[15:0]};
        else if (sel == 54)
            return {`DEC_OPC_COP0, 5'b00000, rnd[20:0]};
        else if (sel == 55)
            return {`DEC_OPC_COP0, 5'b00100, rnd[20:0]};
        else if (sel == 56)
            return {`DEC_OPC_COP0, 5'b10000, rnd[20:6], `DEC_FN_ERET};
        return {`DEC_OPC_SPECIAL2, rnd[25:6], `DEC_FN_MUL};
    endfunction

    task automatic drive_next();
        int unsigned kind;
        int unsigned sel;
        inst_t       rnd;
        inst_t       w;
        kind = $urandom % 8;
        sel  = $urandom % 58;
        rnd  = $urandom;
        w    = rnd;
        if (kind >= 6) begin
            // bubble with an ignored instruction word
            i_valid <= 1'b0;
            i_inst  <= rnd;
            exp_q.push_back(NO_OUTPUT);
        end else begin
            if (kind < 4)
                w = kept_inst(sel, rnd);
            else if (kind == 4)
                w = {DROPPED_OP[2'(sel)], rnd[25:0]};
            i_valid <= 1'b1;
            i_inst  <= w;
            exp_q.push_back(decode_model(w));
        end
    endtask

    task automatic check_field(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        assert (act_val === exp_val) else begin
            $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, exp_val, act_val);
            n_errors++;
        end
    endtask

    task automatic compare_outputs(input exp_t e);
        n_checks++;
        check_field("o_valid", 32'(e.valid), 32'(o_valid));
        check_field("o_br_op", 32'(e.br_op), 32'(o_br_op));
        check_field("o_hilo_op", 32'(e.hilo_op), 32'(o_hilo_op));
        check_field("o_mem_op", 32'(e.mem_op), 32'(o_mem_op));
        check_field("o_cp0_op", 32'(e.cp0_op), 32'(o_cp0_op));
        check_field("o_sel_alu_src1", 32'(e.src1), 32'(o_sel_alu_src1));
        check_field("o_sel_alu_src2", 32'(e.src2), 32'(o_sel_alu_src2));
        check_field("o_alu_op", 32'(e.alu_op), 32'(o_alu_op));
        check_field("o_data_ram_en", 32'(e.ram_en), 32'(o_data_ram_en));
        check_field("o_data_ram_wen", 32'(e.ram_wen), 32'(o_data_ram_wen));
        check_field("o_rf_we", 32'(e.rf_we), 32'(o_rf_we));
        check_field("o_rf_waddr", 32'(e.waddr), 32'(o_rf_waddr));
        check_field("o_sel_rf_res", 32'(e.rf_res), 32'(o_sel_rf_res));
        check_field("o_excepttype", e.exc, o_excepttype);
    endtask

    // an entry pushed at edge N is the output seen after edge N+1
    always @(negedge clk) begin
        if (exp_q.size() > 1) begin
            compare_outputs(exp_q.pop_front());
        end
    end

    initial begin
        void'($urandom(SEED));
        // valid instructions under reset must still give zero outputs
        i_rst_n <= 1'b0;
        i_valid <= 1'b1;
        i_inst  <= kept_inst($urandom % 58, $urandom);
        repeat (3) begin
            @(posedge clk);
            i_inst <= kept_inst($urandom % 58, $urandom);
            exp_q.push_back(NO_OUTPUT);
        end
        @(posedge clk);
        i_rst_n <= 1'b1;
        i_valid <= 1'b0;
        exp_q.push_back(NO_OUTPUT);
        repeat (NUM_TESTS) begin
            @(posedge clk);
            drive_next();
        end
        // trailing bubbles flush the last result
        repeat (2) begin
            @(posedge clk);
            i_valid <= 1'b0;
            exp_q.push_back(NO_OUTPUT);
        end
        @(posedge clk);
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+hdl
hdl/decode_pkg.sv
hdl/decode_if.sv
hdl/inst_classify.sv
hdl/ctrl_encode.sv
hdl/decode_stage.sv
bench/tb_decode_stage.sv

/* hdl/ctrl_encode.sv */
`default_nettype none
`timescale 1ns/1ns

`include "decode_macros.svh"

module ctrl_encode (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    decode_if.encoder             i_dec,
    output logic                  o_valid,
    output decode_pkg::br_op_t    o_br_op,
    output decode_pkg::hilo_op_t  o_hilo_op,
    output decode_pkg::mem_op_t   o_mem_op,
    output decode_pkg::cp0_op_t   o_cp0_op,
    output decode_pkg::src1_sel_t o_sel_alu_src1,
    output decode_pkg::src2_sel_t o_sel_alu_src2,
    output decode_pkg::alu_op_t   o_alu_op,
    output logic                  o_data_ram_en,
    output decode_pkg::ram_wen_t  o_data_ram_wen,
    output logic                  o_rf_we,
    output decode_pkg::reg_addr_t o_rf_waddr,
    output logic                  o_sel_rf_res,
    output decode_pkg::exc_t      o_excepttype
);
    import decode_pkg::*;

    inst_e     id;
    logic      is_load;
    logic      is_store;
    logic      is_link;
    logic      op_add;
    logic      dst_rd;
    logic      dst_rt;
    br_op_t    d_br_op;
    hilo_op_t  d_hilo_op;
    mem_op_t   d_mem_op;
    cp0_op_t   d_cp0_op;
    src1_sel_t d_src1;
    src2_sel_t d_src2;
    alu_op_t   d_alu_op;
    ram_wen_t  d_ram_wen;
    reg_addr_t d_waddr;
    exc_t      d_exc;

    assign id = i_dec.inst_id;

    assign is_load  = id inside {INST_LB, INST_LBU, INST_LH, INST_LHU, INST_LW};
    assign is_store = id inside {INST_SB, INST_SH, INST_SW};
    assign is_link  = id inside {INST_JAL, INST_BLTZAL, INST_BGEZAL, INST_JALR};

    assign d_br_op = {
        id == INST_BEQ,    id == INST_BNE,    id == INST_BGEZ, id == INST_BGTZ,
        id == INST_BLEZ,   id == INST_BLTZ,   id == INST_BGEZAL, id == INST_BLTZAL,
        id == INST_J,      id == INST_JAL,    id == INST_JR,   id == INST_JALR
    };

    assign d_hilo_op = {
        id == INST_MFHI, id == INST_MFLO, id == INST_MTHI, id == INST_MTLO,
        id == INST_MULT, id == INST_MULTU, id == INST_DIV, id == INST_DIVU,
        id == INST_MUL
    };

    assign d_mem_op = {
        id == INST_LB, id == INST_LBU, id == INST_LH, id == INST_LHU, id == INST_LW
    };

    assign d_cp0_op = {id == INST_MFC0, id == INST_MTC0};

    // src1: rs, pc, shift amount
    assign d_src1[0] = is_load | is_store
                     | (id inside {INST_ADD, INST_ADDI, INST_ADDU, INST_ADDIU, INST_SUB,
                                   INST_SUBU, INST_SLT, INST_SLTI, INST_SLTU, INST_SLTIU,
                                   INST_DIV, INST_DIVU, INST_MUL, INST_MULT, INST_MULTU,
                                   INST_AND, INST_ANDI, INST_NOR, INST_OR, INST_ORI,
                                   INST_XOR, INST_XORI, INST_SLLV, INST_SRAV, INST_SRLV,
                                   INST_MTHI, INST_MTLO});
    assign d_src1[1] = is_link;
    assign d_src1[2] = id inside {INST_SLL, INST_SRA, INST_SRL};

    // src2: rt, sign-extended imm, 8, zero-extended imm
    assign d_src2[0] = id inside {INST_ADD, INST_ADDU, INST_SUB, INST_SUBU, INST_SLT,
                                  INST_SLTU, INST_DIV, INST_DIVU, INST_MUL, INST_MULT,
                                  INST_MULTU, INST_AND, INST_NOR, INST_OR, INST_XOR,
                                  INST_SLLV, INST_SLL, INST_SRAV, INST_SRA, INST_SRLV,
                                  INST_SRL};
    assign d_src2[1] = is_load | is_store
                     | (id inside {INST_ADDI, INST_ADDIU, INST_LUI, INST_SLTI, INST_SLTIU});
    assign d_src2[2] = is_link;
    assign d_src2[3] = id inside {INST_ORI, INST_ANDI, INST_XORI};

    // address generation and link return share the adder
    assign op_add = is_load | is_store | is_link
                  | (id inside {INST_ADD, INST_ADDU, INST_ADDI, INST_ADDIU});

    assign d_alu_op = {
        id inside {INST_ADD, INST_ADDI, INST_SUB},
        id inside {INST_MFHI, INST_MFLO},
        op_add,
        id inside {INST_SUB, INST_SUBU},
        id inside {INST_SLT, INST_SLTI},
        id inside {INST_SLTU, INST_SLTIU},
        id inside {INST_AND, INST_ANDI},
        id == INST_NOR,
        id inside {INST_OR, INST_ORI},
        id inside {INST_XOR, INST_XORI},
        id inside {INST_SLL, INST_SLLV},
        id inside {INST_SRL, INST_SRLV},
        id inside {INST_SRA, INST_SRAV},
        id == INST_LUI
    };

    assign d_ram_wen = {1'b0, id == INST_SB, id == INST_SH, id == INST_SW};

    // destination select, at most one is set
    assign dst_rd = id inside {INST_ADD, INST_ADDU, INST_SUB, INST_SUBU, INST_SLT, INST_SLTU,
                               INST_SLLV, INST_SLL, INST_SRLV, INST_SRL, INST_SRAV, INST_SRA,
                               INST_AND, INST_OR, INST_XOR, INST_NOR, INST_MFHI, INST_MFLO,
                               INST_MUL};
    assign dst_rt = is_load
                  | (id inside {INST_ADDI, INST_ADDIU, INST_LUI, INST_ORI, INST_ANDI,
                                INST_XORI, INST_SLTI, INST_SLTIU, INST_MFC0});

    assign d_waddr = ({`DEC_REG_W{dst_rd}} & i_dec.rd)
                   | ({`DEC_REG_W{dst_rt}} & i_dec.rt)
                   | ({`DEC_REG_W{is_link}} & `DEC_LINK_REG);

    always_comb begin
        d_exc = '0;
        d_exc[`DEC_EXC_SYSCALL] = (id == INST_SYSCALL);
        d_exc[`DEC_EXC_INVALID] = (id == INST_INVALID);
        d_exc[`DEC_EXC_ERET]    = (id == INST_ERET);
        d_exc[`DEC_EXC_BREAK]   = (id == INST_BREAK);
    end

    // stage register into execute, bubbles load all zeros
    always_ff @(posedge i_clk) begin
        if (!i_rst_n || !i_dec.valid) begin
            {o_valid, o_br_op, o_hilo_op, o_mem_op, o_cp0_op,
             o_sel_alu_src1, o_sel_alu_src2, o_alu_op,
             o_data_ram_en, o_data_ram_wen, o_rf_we, o_rf_waddr,
             o_sel_rf_res, o_excepttype} <= '0;
        end else begin
            o_valid        <= 1'b1;
            o_br_op        <= d_br_op;
            o_hilo_op      <= d_hilo_op;
            o_mem_op       <= d_mem_op;
            o_cp0_op       <= d_cp0_op;
            o_sel_alu_src1 <= d_src1;
            o_sel_alu_src2 <= d_src2;
            o_alu_op       <= d_alu_op;
            o_data_ram_en  <= is_load | is_store;
            o_data_ram_wen <= d_ram_wen;
            o_rf_we        <= dst_rd | dst_rt | is_link;
            o_rf_waddr     <= d_waddr;
            o_sel_rf_res   <= is_load;
            o_excepttype   <= d_exc;
        end
    end

endmodule

`default_nettype wire

/* hdl/decode_if.sv */
`default_nettype none
`timescale 1ns/1ns

interface decode_if;
    import decode_pkg::*;

    logic      valid;
    inst_e     inst_id;
    reg_addr_t rt;
    reg_addr_t rd;

    modport classifier (
        output valid, inst_id, rt, rd
    );

    modport encoder (
        input valid, inst_id, rt, rd
    );

endinterface

`default_nettype wire

/* hdl/decode_macros.svh */
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// field and bus widths
`define DEC_INST_W      32
`define DEC_OP_W        6
`define DEC_REG_W       5
`define DEC_ID_W        6
`define DEC_EXC_W       32
`define DEC_BR_OP_W     12
`define DEC_HILO_OP_W   9
`define DEC_MEM_OP_W    5
`define DEC_CP0_OP_W    2
`define DEC_ALU_OP_W    14
`define DEC_SRC1_W      3
`define DEC_SRC2_W      4
`define DEC_WEN_W       4

// major opcodes that need a second field
`define DEC_OPC_SPECIAL     6'b000000
`define DEC_OPC_REGIMM      6'b000001
`define DEC_OPC_COP0        6'b010000
`define DEC_OPC_SPECIAL2    6'b011100

// SPECIAL function codes
`define DEC_FN_SLL          6'b000000
`define DEC_FN_SRL          6'b000010
`define DEC_FN_SRA          6'b000011
`define DEC_FN_SLLV         6'b000100
`define DEC_FN_SRLV         6'b000110
`define DEC_FN_SRAV         6'b000111
`define DEC_FN_JR           6'b001000
`define DEC_FN_JALR         6'b001001
`define DEC_FN_SYSCALL      6'b001100
`define DEC_FN_BREAK        6'b001101
`define DEC_FN_MFHI         6'b010000
`define DEC_FN_MTHI         6'b010001
`define DEC_FN_MFLO         6'b010010
`define DEC_FN_MTLO         6'b010011
`define DEC_FN_MULT         6'b011000
`define DEC_FN_MULTU        6'b011001
`define DEC_FN_DIV          6'b011010
`define DEC_FN_DIVU         6'b011011
`define DEC_FN_ADD          6'b100000
`define DEC_FN_ADDU         6'b100001
`define DEC_FN_SUB          6'b100010
`define DEC_FN_SUBU         6'b100011
`define DEC_FN_AND          6'b100100
`define DEC_FN_OR           6'b100101
`define DEC_FN_XOR          6'b100110
`define DEC_FN_NOR          6'b100111
`define DEC_FN_SLT          6'b101010
`define DEC_FN_SLTU         6'b101011

// SPECIAL2 and COP0 function codes
`define DEC_FN_MUL          6'b000010
`define DEC_FN_ERET         6'b011000

// destination of the and-link forms
`define DEC_LINK_REG        5'd31

// bit positions in the exception word
`define DEC_EXC_SYSCALL     8
`define DEC_EXC_INVALID     9
`define DEC_EXC_ERET        12
`define DEC_EXC_BREAK       13

`endif

/* hdl/decode_pkg.sv */
`default_nettype none

`include "decode_macros.svh"

package decode_pkg;

    typedef logic [`DEC_INST_W-1:0]    inst_t;
    typedef logic [`DEC_OP_W-1:0]      opcode_t;
    typedef logic [`DEC_REG_W-1:0]     reg_addr_t;

    // control vectors handed to execute
    typedef logic [`DEC_BR_OP_W-1:0]   br_op_t;
    typedef logic [`DEC_HILO_OP_W-1:0] hilo_op_t;
    typedef logic [`DEC_MEM_OP_W-1:0]  mem_op_t;
    typedef logic [`DEC_CP0_OP_W-1:0]  cp0_op_t;
    typedef logic [`DEC_ALU_OP_W-1:0]  alu_op_t;
    typedef logic [`DEC_SRC1_W-1:0]    src1_sel_t;
    typedef logic [`DEC_SRC2_W-1:0]    src2_sel_t;
    typedef logic [`DEC_WEN_W-1:0]     ram_wen_t;
    typedef logic [`DEC_EXC_W-1:0]     exc_t;

    // invalid sits at zero so that any unmatched encoding falls into it
    typedef enum logic [`DEC_ID_W-1:0] {
        INST_INVALID,
        // arithmetic and compare
        INST_ADD, INST_ADDI, INST_ADDU, INST_ADDIU, INST_SUB, INST_SUBU,
        INST_SLT, INST_SLTI, INST_SLTU, INST_SLTIU,
        // multiply and divide
        INST_DIV, INST_DIVU, INST_MUL, INST_MULT, INST_MULTU,
        // logic
        INST_AND, INST_ANDI, INST_LUI, INST_NOR, INST_OR, INST_ORI,
        INST_XOR, INST_XORI,
        // shifts
        INST_SLL, INST_SLLV, INST_SRA, INST_SRAV, INST_SRL, INST_SRLV,
        // branches and jumps
        INST_BEQ, INST_BNE, INST_BGEZ, INST_BGTZ, INST_BLEZ, INST_BLTZ,
        INST_BGEZAL, INST_BLTZAL, INST_J, INST_JAL, INST_JR, INST_JALR,
        // hi/lo moves
        INST_MFHI, INST_MFLO, INST_MTHI, INST_MTLO,
        // loads and stores
        INST_LB, INST_LBU, INST_LH, INST_LHU, INST_LW,
        INST_SB, INST_SH, INST_SW,
        // traps and cop0
        INST_BREAK, INST_SYSCALL, INST_ERET, INST_MFC0, INST_MTC0
    } inst_e;

endpackage

`default_nettype wire

/* hdl/decode_stage.sv */
`default_nettype none
`timescale 1ns/1ns

module decode_stage (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_valid,
    input  decode_pkg::inst_t     i_inst,
    output logic                  o_valid,
    output decode_pkg::br_op_t    o_br_op,
    output decode_pkg::hilo_op_t  o_hilo_op,
    output decode_pkg::mem_op_t   o_mem_op,
    output decode_pkg::cp0_op_t   o_cp0_op,
    output decode_pkg::src1_sel_t o_sel_alu_src1,
    output decode_pkg::src2_sel_t o_sel_alu_src2,
    output decode_pkg::alu_op_t   o_alu_op,
    output logic                  o_data_ram_en,
    output decode_pkg::ram_wen_t  o_data_ram_wen,
    output logic                  o_rf_we,
    output decode_pkg::reg_addr_t o_rf_waddr,
    output logic                  o_sel_rf_res,
    output decode_pkg::exc_t      o_excepttype
);

    // classified instruction, same cycle as i_inst
    decode_if u_dec_if ();

    inst_classify u_classify (
        .i_inst  (i_inst),
        .i_valid (i_valid),
        .o_dec   (u_dec_if.classifier)
    );

    ctrl_encode u_encode (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_dec          (u_dec_if.encoder),
        .o_valid        (o_valid),
        .o_br_op        (o_br_op),
        .o_hilo_op      (o_hilo_op),
        .o_mem_op       (o_mem_op),
        .o_cp0_op       (o_cp0_op),
        .o_sel_alu_src1 (o_sel_alu_src1),
        .o_sel_alu_src2 (o_sel_alu_src2),
        .o_alu_op       (o_alu_op),
        .o_data_ram_en  (o_data_ram_en),
        .o_data_ram_wen (o_data_ram_wen),
        .o_rf_we        (o_rf_we),
        .o_rf_waddr     (o_rf_waddr),
        .o_sel_rf_res   (o_sel_rf_res),
        .o_excepttype   (o_excepttype)
    );

endmodule

`default_nettype wire

/* hdl/inst_classify.sv */
`default_nettype none
`timescale 1ns/1ns

`include "decode_macros.svh"

module inst_classify (
    input  decode_pkg::inst_t i_inst,
    input  logic              i_valid,
    decode_if.classifier      o_dec
);
    import decode_pkg::*;

    opcode_t   opcode;
    opcode_t   func;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    inst_e     inst_id;

    assign opcode = i_inst[31:26];
    assign rs     = i_inst[25:21];
    assign rt     = i_inst[20:16];
    assign rd     = i_inst[15:11];
    assign func   = i_inst[5:0];

    always_comb begin
        inst_id = INST_INVALID;
        case (opcode)
            `DEC_OPC_SPECIAL: begin
                case (func)
                    `DEC_FN_SLL:     inst_id = INST_SLL;
                    `DEC_FN_SRL:     inst_id = INST_SRL;
                    `DEC_FN_SRA:     inst_id = INST_SRA;
                    `DEC_FN_SLLV:    inst_id = INST_SLLV;
                    `DEC_FN_SRLV:    inst_id = INST_SRLV;
                    `DEC_FN_SRAV:    inst_id = INST_SRAV;
                    `DEC_FN_JR:      inst_id = INST_JR;
                    `DEC_FN_JALR:    inst_id = INST_JALR;
                    `DEC_FN_SYSCALL: inst_id = INST_SYSCALL;
                    `DEC_FN_BREAK:   inst_id = INST_BREAK;
                    `DEC_FN_MFHI:    inst_id = INST_MFHI;
                    `DEC_FN_MTHI:    inst_id = INST_MTHI;
                    `DEC_FN_MFLO:    inst_id = INST_MFLO;
                    `DEC_FN_MTLO:    inst_id = INST_MTLO;
                    `DEC_FN_MULT:    inst_id = INST_MULT;
                    `DEC_FN_MULTU:   inst_id = INST_MULTU;
                    `DEC_FN_DIV:     inst_id = INST_DIV;
                    `DEC_FN_DIVU:    inst_id = INST_DIVU;
                    `DEC_FN_ADD:     inst_id = INST_ADD;
                    `DEC_FN_ADDU:    inst_id = INST_ADDU;
                    `DEC_FN_SUB:     inst_id = INST_SUB;
                    `DEC_FN_SUBU:    inst_id = INST_SUBU;
                    `DEC_FN_AND:     inst_id = INST_AND;
                    `DEC_FN_OR:      inst_id = INST_OR;
                    `DEC_FN_XOR:     inst_id = INST_XOR;
                    `DEC_FN_NOR:     inst_id = INST_NOR;
                    `DEC_FN_SLT:     inst_id = INST_SLT;
                    `DEC_FN_SLTU:    inst_id = INST_SLTU;
                    // sync and the traps land here
                    default:         inst_id = INST_INVALID;
                endcase
            end
            `DEC_OPC_REGIMM: begin
                // rt picks the compare, bit 4 adds the link
                case (rt)
                    5'b00000: inst_id = INST_BLTZ;
                    5'b00001: inst_id = INST_BGEZ;
                    5'b10000: inst_id = INST_BLTZAL;
                    5'b10001: inst_id = INST_BGEZAL;
                    default:  inst_id = INST_INVALID;
                endcase
            end
            `DEC_OPC_COP0: begin
                case (rs)
                    5'b00000: inst_id = INST_MFC0;
                    5'b00100: inst_id = INST_MTC0;
                    // CO group, only eret is kept
                    5'b10000: inst_id = (func == `DEC_FN_ERET) ? INST_ERET : INST_INVALID;
                    default:  inst_id = INST_INVALID;
                endcase
            end
            `DEC_OPC_SPECIAL2: begin
                inst_id = (func == `DEC_FN_MUL) ? INST_MUL : INST_INVALID;
            end
            6'b000010: inst_id = INST_J;
            6'b000011: inst_id = INST_JAL;
            6'b000100: inst_id = INST_BEQ;
            6'b000101: inst_id = INST_BNE;
            6'b000110: inst_id = INST_BLEZ;
            6'b000111: inst_id = INST_BGTZ;
            6'b001000: inst_id = INST_ADDI;
            6'b001001: inst_id = INST_ADDIU;
            6'b001010: inst_id = INST_SLTI;
            6'b001011: inst_id = INST_SLTIU;
            6'b001100: inst_id = INST_ANDI;
            6'b001101: inst_id = INST_ORI;
            6'b001110: inst_id = INST_XORI;
            6'b001111: inst_id = INST_LUI;
            6'b100000: inst_id = INST_LB;
            6'b100001: inst_id = INST_LH;
            6'b100011: inst_id = INST_LW;
            6'b100100: inst_id = INST_LBU;
            6'b100101: inst_id = INST_LHU;
            6'b101000: inst_id = INST_SB;
            6'b101001: inst_id = INST_SH;
            6'b101011: inst_id = INST_SW;
            // likely branches, unaligned access, cache
            default:   inst_id = INST_INVALID;
        endcase
    end

    assign o_dec.valid   = i_valid;
    assign o_dec.inst_id = inst_id;
    assign o_dec.rt      = rt;
    assign o_dec.rd      = rd;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_decode_stage -o tb_decode_stage
./obj_dir/tb_decode_stage | tee sim.log

if grep -q "Testbench failed" sim.log; then
    echo "simulation reported errors, see sim.log"
    exit 1
fi
echo "simulation finished cleanly"
